// File: include/periph_consts.svh
// ================================================
// widths, defaults and bus constants of the UART block
// register indices are byte address bits [7:2]
// ================================================
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

`define UART_BAUD_DEFAULT     54            // clocks per bit out of reset
`define UART_BAUD_W           16
`define UART_FIFO_DEPTH_LOG2  4             // 16 entries per FIFO
`define UART_ENTRY_W          9             // error flag + byte

`define AXI_ADDR_W            8
`define AXI_DATA_W            32

`define LED_W                 8
`define DIP_W                 16

`define REG_BAD_DATA          32'hDEADBEEF  // unmapped read word

`endif

// File: source/periph_pkg.sv
// ================================================
// state, register index and response encodings
// ================================================
package periph_pkg;

   typedef enum logic [1:0] {UTX_IDLE, UTX_POP, UTX_START, UTX_BUSY} utx_state_e;

   typedef enum logic [1:0] {URX_IDLE, URX_START, URX_DATA, URX_STOP} urx_state_e;

   // word index, byte address is index * 4
   typedef enum logic [5:0] {
      REG_TXDATA = 6'd0,     // 0x00
      REG_RXDATA = 6'd1,     // 0x04
      REG_RXPOP  = 6'd2,     // 0x08
      REG_BAUD   = 6'd3,     // 0x0C
      REG_STATUS = 6'd4,     // 0x10
      REG_LED    = 6'd5,     // 0x14
      REG_DIP    = 6'd6      // 0x18, last mapped index
   } reg_addr_e;

   typedef enum logic [1:0] {
      AXI_OKAY   = 2'b00,
      AXI_SLVERR = 2'b10
   } axi_resp_e;

endpackage

// File: source/sync_fifo.sv
// ================================================
// first-word-fall-through FIFO, head valid when not empty
// push when full and pop when empty are ignored
// ================================================
`timescale 1ns/10ps

module sync_fifo
#(
   parameter int WIDTH      = 9,
   parameter int DEPTH_LOG2 = 4
)
(
   input  logic                 msoc_clk,
   input  logic                 rstn,
   input  logic                 push_i,
   input  logic [WIDTH-1:0]     data_i,
   input  logic                 pop_i,
   output logic [WIDTH-1:0]     head_o,
   output logic [DEPTH_LOG2:0]  count_o,
   output logic                 full_o,
   output logic                 empty_o
);

   logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
   logic [DEPTH_LOG2-1:0] wptr, rptr;
   logic                  do_push, do_pop;

   assign full_o  = count_o[DEPTH_LOG2];   // count equals depth
   assign empty_o = count_o == '0;
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;
   assign head_o  = mem[rptr];

   always_ff @(posedge msoc_clk)
      if (do_push)
         mem[wptr] <= data_i;

   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         wptr    <= '0;
         rptr    <= '0;
         count_o <= '0;
      end
      else
      begin
         if (do_push)
            wptr <= wptr + 1'b1;   // wraps at depth
         if (do_pop)
            rptr <= rptr + 1'b1;
         count_o <= count_o + (DEPTH_LOG2+1)'(do_push) - (DEPTH_LOG2+1)'(do_pop);
      end

endmodule

// File: source/axil_slave.sv
// ================================================
// AXI4-Lite slave, one write and one read outstanding
// bvalid two cycles after the write strobe, rvalid two after AR
// ================================================
`timescale 1ns/10ps
`include "periph_consts.svh"

module axil_slave
(
   input  logic                    msoc_clk,
   input  logic                    rstn,
   input  logic [`AXI_ADDR_W-1:0]  awaddr_i,
   input  logic                    awvalid_i,
   output logic                    awready_o,
   input  logic [`AXI_DATA_W-1:0]  wdata_i,
   input  logic                    wvalid_i,
   output logic                    wready_o,
   output logic [1:0]              bresp_o,
   output logic                    bvalid_o,
   input  logic                    bready_i,
   input  logic [`AXI_ADDR_W-1:0]  araddr_i,
   input  logic                    arvalid_i,
   output logic                    arready_o,
   output logic [`AXI_DATA_W-1:0]  rdata_o,
   output logic [1:0]              rresp_o,
   output logic                    rvalid_o,
   input  logic                    rready_i,
   output logic                    reg_wr_o,
   output logic                    reg_rd_o,
   output logic [`AXI_ADDR_W-3:0]  reg_widx_o,
   output logic [`AXI_ADDR_W-3:0]  reg_ridx_o,
   output logic [`AXI_DATA_W-1:0]  reg_wdata_o,
   input  logic [`AXI_DATA_W-1:0]  reg_rdata_i,
   input  logic                    reg_decerr_i
);

   logic                   aw_got, w_got;   // channel captured
   logic                   wr_q, rd_q;      // strobes delayed one cycle
   logic [`AXI_ADDR_W-3:0] widx_q;
   logic [`AXI_DATA_W-1:0] wdata_q;
   logic [`AXI_DATA_W-1:0] rdata_q;
   periph_pkg::axi_resp_e  bresp_q, rresp_q;

   assign reg_rd_o    = arvalid_i & arready_o;
   assign reg_ridx_o  = araddr_i[`AXI_ADDR_W-1:2];
   assign reg_wr_o    = aw_got & w_got & ~reg_rd_o;   // yields to a read strobe
   assign reg_widx_o  = widx_q;
   assign reg_wdata_o = wdata_q;
   assign bresp_o     = bresp_q;
   assign rresp_o     = rresp_q;
   assign rdata_o     = rdata_q;

   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         aw_got    <= 1'b0;
         w_got     <= 1'b0;
         wr_q      <= 1'b0;
         bvalid_o  <= 1'b0;
         bresp_q   <= periph_pkg::AXI_OKAY;
         arready_o <= 1'b0;
         rd_q      <= 1'b0;
         rvalid_o  <= 1'b0;
         rresp_q   <= periph_pkg::AXI_OKAY;
      end
      else
      begin
         wr_q <= reg_wr_o;
         rd_q <= reg_rd_o;
         if (awready_o && awvalid_i)
         begin
            awready_o <= 1'b0;
            aw_got    <= 1'b1;
         end
         else if (!aw_got && !wr_q && !bvalid_o)
            awready_o <= 1'b1;
         if (wready_o && wvalid_i)
         begin
            wready_o <= 1'b0;
            w_got    <= 1'b1;
         end
         else if (!w_got && !wr_q && !bvalid_o)
            wready_o <= 1'b1;
         if (reg_wr_o)
         begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
         end
         if (wr_q)
         begin
            bvalid_o <= 1'b1;
            bresp_q  <= reg_decerr_i ? periph_pkg::AXI_SLVERR : periph_pkg::AXI_OKAY;
         end
         else if (bvalid_o && bready_i)
            bvalid_o <= 1'b0;
         if (reg_rd_o)
            arready_o <= 1'b0;
         else if (!rd_q && !rvalid_o)
            arready_o <= 1'b1;   // no read pending
         if (rd_q)
         begin
            rvalid_o <= 1'b1;
            rresp_q  <= reg_decerr_i ? periph_pkg::AXI_SLVERR : periph_pkg::AXI_OKAY;
         end
         else if (rvalid_o && rready_i)
            rvalid_o <= 1'b0;
      end

   always_ff @(posedge msoc_clk)
   begin
      if (awready_o && awvalid_i)
         widx_q <= awaddr_i[`AXI_ADDR_W-1:2];
      if (wready_o && wvalid_i)
         wdata_q <= wdata_i;
      if (rd_q)
         rdata_q <= reg_rdata_i;   // held until rready
   end

endmodule

// File: source/uart_regs.sv
// ================================================
// register map, read word and decode error one cycle late
// write and read strobes never come in the same cycle
// ================================================
`timescale 1ns/10ps
`include "periph_consts.svh"

module uart_regs
(
   input  logic                            msoc_clk,
   input  logic                            rstn,
   input  logic                            reg_wr_i,
   input  logic                            reg_rd_i,
   input  logic [`AXI_ADDR_W-3:0]          reg_widx_i,
   input  logic [`AXI_ADDR_W-3:0]          reg_ridx_i,
   input  logic [`AXI_DATA_W-1:0]          reg_wdata_i,
   input  logic [`DIP_W-1:0]               dip_i,
   input  logic [`UART_FIFO_DEPTH_LOG2:0]  tx_count_i,
   input  logic                            tx_full_i,
   input  logic                            tx_empty_i,
   input  logic [`UART_ENTRY_W-1:0]        rx_head_i,
   input  logic [`UART_FIFO_DEPTH_LOG2:0]  rx_count_i,
   input  logic                            rx_full_i,
   input  logic                            rx_empty_i,
   output logic [`AXI_DATA_W-1:0]          reg_rdata_o,
   output logic                            reg_decerr_o,
   output logic                            tx_push_o,
   output logic [7:0]                      tx_data_o,
   output logic                            rx_pop_o,
   output logic [`UART_BAUD_W-1:0]         baud_o,
   output logic [`LED_W-1:0]               led_o
);

   periph_pkg::reg_addr_e  widx, ridx;
   logic [`DIP_W-1:0]      dip_q;
   logic [`AXI_DATA_W-1:0] rd_word;

   assign widx      = periph_pkg::reg_addr_e'(reg_widx_i);
   assign ridx      = periph_pkg::reg_addr_e'(reg_ridx_i);
   assign tx_push_o = reg_wr_i && widx == periph_pkg::REG_TXDATA;   // dropped by FIFO when full
   assign tx_data_o = reg_wdata_i[7:0];
   assign rx_pop_o  = reg_wr_i && widx == periph_pkg::REG_RXPOP;

   always_comb
   begin
      rd_word = '0;
      case (ridx)
         periph_pkg::REG_RXDATA: rd_word[9:0] = {rx_empty_i, rx_head_i};
         periph_pkg::REG_BAUD:   rd_word[`UART_BAUD_W-1:0] = baud_o;
         periph_pkg::REG_STATUS:
            rd_word[13:0] = {rx_count_i, tx_count_i, rx_full_i, rx_empty_i,
                             tx_full_i, tx_empty_i};
         periph_pkg::REG_LED:    rd_word[`LED_W-1:0] = led_o;
         periph_pkg::REG_DIP:    rd_word[`DIP_W-1:0] = dip_q;
         periph_pkg::REG_TXDATA,
         periph_pkg::REG_RXPOP:  rd_word = '0;   // write-only
         default:                rd_word = `REG_BAD_DATA;
      endcase
   end

   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         baud_o       <= `UART_BAUD_DEFAULT;
         led_o        <= '0;
         dip_q        <= '0;
         reg_decerr_o <= 1'b0;
      end
      else
      begin
         dip_q <= dip_i;
         // indices are contiguous up to REG_DIP
         if (reg_rd_i)
            reg_decerr_o <= reg_ridx_i > periph_pkg::REG_DIP;
         else if (reg_wr_i)
            reg_decerr_o <= reg_widx_i > periph_pkg::REG_DIP;
         if (reg_wr_i && widx == periph_pkg::REG_BAUD)
            baud_o <= reg_wdata_i[`UART_BAUD_W-1:0];   // used from the next frame
         if (reg_wr_i && widx == periph_pkg::REG_LED)
            led_o <= reg_wdata_i[`LED_W-1:0];
      end

   always_ff @(posedge msoc_clk)
      if (reg_rd_i)
         reg_rdata_o <= rd_word;

endmodule

// File: source/uart_tx.sv
// ================================================
// 8N1 transmitter, LSB first, line high when idle
// baud is taken once per frame
// ================================================
`timescale 1ns/10ps
`include "periph_consts.svh"

module uart_tx
(
   input  logic                    msoc_clk,
   input  logic                    rstn,
   input  logic [`UART_BAUD_W-1:0] baud_i,
   input  logic                    fifo_empty_i,
   input  logic [7:0]              fifo_data_i,
   output logic                    fifo_pop_o,
   output logic                    tx_o
);

   periph_pkg::utx_state_e  state_q;
   logic [`UART_BAUD_W-1:0] bit_baud;   // clocks per bit for this frame
   logic [`UART_BAUD_W-1:0] cnt;
   logic [3:0]              bitn;
   logic [9:0]              frame;      // stop, data, start
   logic                    bit_end;

   assign fifo_pop_o = state_q == periph_pkg::UTX_POP;
   assign tx_o       = (state_q == periph_pkg::UTX_BUSY) ? frame[0] : 1'b1;
   assign bit_end    = cnt == bit_baud - 1'b1;

   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         state_q <= periph_pkg::UTX_IDLE;
         cnt     <= '0;
         bitn    <= '0;
      end
      else
         case (state_q)
            periph_pkg::UTX_IDLE:
               if (!fifo_empty_i)
                  state_q <= periph_pkg::UTX_POP;
            periph_pkg::UTX_POP:
               state_q <= periph_pkg::UTX_START;
            periph_pkg::UTX_START:
            begin
               cnt     <= '0;
               bitn    <= '0;
               state_q <= periph_pkg::UTX_BUSY;
            end
            default:
               if (bit_end)
               begin
                  cnt  <= '0;
                  bitn <= bitn + 1'b1;
                  if (bitn == 4'd9)   // stop bit done
                     state_q <= periph_pkg::UTX_IDLE;
               end
               else
                  cnt <= cnt + 1'b1;
         endcase

   always_ff @(posedge msoc_clk)
      if (state_q == periph_pkg::UTX_POP)
      begin
         frame    <= {1'b1, fifo_data_i, 1'b0};
         bit_baud <= baud_i;
      end
      else if (state_q == periph_pkg::UTX_BUSY && bit_end)
         frame <= {1'b1, frame[9:1]};

endmodule

// File: source/uart_rx.sv
// ================================================
// 8N1 receiver behind a 3-sample majority filter (2 cycles)
// entry is pushed mid stop bit, bit 8 set on a low stop bit
// ================================================
`timescale 1ns/10ps
`include "periph_consts.svh"

module uart_rx
(
   input  logic                     msoc_clk,
   input  logic                     rstn,
   input  logic [`UART_BAUD_W-1:0]  baud_i,
   input  logic                     rx_i,
   output logic                     push_o,
   output logic [`UART_ENTRY_W-1:0] entry_o
);

   periph_pkg::urx_state_e  state_q;
   logic [2:0]              filt;
   logic                    maj, maj_q;
   logic [`UART_BAUD_W-1:0] bit_baud;
   logic [`UART_BAUD_W-1:0] cnt;
   logic [2:0]              bitn;
   logic [7:0]              shreg;
   logic                    bit_end;

   assign maj     = (filt[0] & filt[1]) | (filt[1] & filt[2]) | (filt[0] & filt[2]);
   assign bit_end = cnt == bit_baud - 1'b1;
   assign push_o  = state_q == periph_pkg::URX_STOP && bit_end;
   assign entry_o = {~maj, shreg};   // framing error when stop samples low

   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         filt    <= 3'b111;   // idle line
         maj_q   <= 1'b1;
         state_q <= periph_pkg::URX_IDLE;
         cnt     <= '0;
         bitn    <= '0;
      end
      else
      begin
         filt  <= {filt[1:0], rx_i};
         maj_q <= maj;
         case (state_q)
            periph_pkg::URX_IDLE:
               if (maj_q && !maj)   // falling edge of start bit
               begin
                  cnt     <= '0;
                  state_q <= periph_pkg::URX_START;
               end
            periph_pkg::URX_START:
               if (cnt == bit_baud >> 1)
               begin
                  cnt     <= '0;
                  bitn    <= '0;
                  state_q <= maj ? periph_pkg::URX_IDLE : periph_pkg::URX_DATA;
               end
               else
                  cnt <= cnt + 1'b1;
            periph_pkg::URX_DATA:
               if (bit_end)
               begin
                  cnt  <= '0;
                  bitn <= bitn + 1'b1;
                  if (bitn == 3'd7)
                     state_q <= periph_pkg::URX_STOP;
               end
               else
                  cnt <= cnt + 1'b1;
            default:
               if (bit_end)
                  state_q <= periph_pkg::URX_IDLE;
               else
                  cnt <= cnt + 1'b1;
         endcase
      end

   always_ff @(posedge msoc_clk)
   begin
      if (state_q == periph_pkg::URX_IDLE)
         bit_baud <= baud_i;   // frozen once the start edge is seen
      if (state_q == periph_pkg::URX_DATA && bit_end)
         shreg <= {maj, shreg[7:1]};   // LSB arrives first
   end

endmodule

// File: source/periph_uart_top.sv
// ================================================
// AXI4-Lite UART peripheral, one write and one read in flight
// wstrb is not used, registers are always written whole
// ================================================
`timescale 1ns/10ps
`include "periph_consts.svh"

module periph_uart_top
(
   input  logic                      msoc_clk,
   input  logic                      rstn,
   input  logic [`AXI_ADDR_W-1:0]    awaddr_i,
   input  logic                      awvalid_i,
   output logic                      awready_o,
   input  logic [`AXI_DATA_W-1:0]    wdata_i,
   input  logic [`AXI_DATA_W/8-1:0]  wstrb_i,
   input  logic                      wvalid_i,
   output logic                      wready_o,
   output logic [1:0]                bresp_o,
   output logic                      bvalid_o,
   input  logic                      bready_i,
   input  logic [`AXI_ADDR_W-1:0]    araddr_i,
   input  logic                      arvalid_i,
   output logic                      arready_o,
   output logic [`AXI_DATA_W-1:0]    rdata_o,
   output logic [1:0]                rresp_o,
   output logic                      rvalid_o,
   input  logic                      rready_i,
   input  logic                      uart_rx_i,
   output logic                      uart_tx_o,
   output logic                      uart_irq_o,
   output logic [`LED_W-1:0]         led_o,
   input  logic [`DIP_W-1:0]         dip_i
);

   logic                           reg_wr;
   logic                           reg_rd;
   logic                           reg_decerr;
   logic [`AXI_ADDR_W-3:0]         reg_widx;
   logic [`AXI_ADDR_W-3:0]         reg_ridx;
   logic [`AXI_DATA_W-1:0]         reg_wdata;
   logic [`AXI_DATA_W-1:0]         reg_rdata;
   logic                           tx_push, tx_pop, tx_full, tx_empty;
   logic [7:0]                     tx_data, tx_head;
   logic                           rx_push, rx_pop, rx_full, rx_empty;
   logic [`UART_ENTRY_W-1:0]       rx_entry, rx_head;
   logic [`UART_FIFO_DEPTH_LOG2:0] tx_count, rx_count;
   logic [`UART_BAUD_W-1:0]        baud;

   assign uart_irq_o = ~rx_empty;   // level, follows the rx FIFO

   axil_slave u_axil (
      .msoc_clk, .rstn,
      .awaddr_i, .awvalid_i, .awready_o,
      .wdata_i, .wvalid_i, .wready_o,
      .bresp_o, .bvalid_o, .bready_i,
      .araddr_i, .arvalid_i, .arready_o,
      .rdata_o, .rresp_o, .rvalid_o, .rready_i,
      .reg_wr_o(reg_wr), .reg_rd_o(reg_rd),
      .reg_widx_o(reg_widx), .reg_ridx_o(reg_ridx),
      .reg_wdata_o(reg_wdata),
      .reg_rdata_i(reg_rdata), .reg_decerr_i(reg_decerr)
   );

   uart_regs u_regs (
      .msoc_clk, .rstn,
      .reg_wr_i(reg_wr), .reg_rd_i(reg_rd),
      .reg_widx_i(reg_widx), .reg_ridx_i(reg_ridx),
      .reg_wdata_i(reg_wdata), .dip_i,
      .tx_count_i(tx_count), .tx_full_i(tx_full), .tx_empty_i(tx_empty),
      .rx_head_i(rx_head), .rx_count_i(rx_count),
      .rx_full_i(rx_full), .rx_empty_i(rx_empty),
      .reg_rdata_o(reg_rdata), .reg_decerr_o(reg_decerr),
      .tx_push_o(tx_push), .tx_data_o(tx_data), .rx_pop_o(rx_pop),
      .baud_o(baud), .led_o
   );

   sync_fifo #(.WIDTH(8), .DEPTH_LOG2(`UART_FIFO_DEPTH_LOG2)) tx_fifo (
      .msoc_clk, .rstn,
      .push_i(tx_push), .data_i(tx_data), .pop_i(tx_pop),
      .head_o(tx_head), .count_o(tx_count), .full_o(tx_full), .empty_o(tx_empty)
   );

   sync_fifo #(.WIDTH(`UART_ENTRY_W), .DEPTH_LOG2(`UART_FIFO_DEPTH_LOG2)) rx_fifo (
      .msoc_clk, .rstn,
      .push_i(rx_push), .data_i(rx_entry), .pop_i(rx_pop),
      .head_o(rx_head), .count_o(rx_count), .full_o(rx_full), .empty_o(rx_empty)
   );

   uart_tx u_tx (
      .msoc_clk, .rstn, .baud_i(baud),
      .fifo_empty_i(tx_empty), .fifo_data_i(tx_head),
      .fifo_pop_o(tx_pop), .tx_o(uart_tx_o)
   );

   uart_rx u_rx (
      .msoc_clk, .rstn, .baud_i(baud), .rx_i(uart_rx_i),
      .push_o(rx_push), .entry_o(rx_entry)
   );

endmodule

// File: dv/uart_assertions.sv
// ================================================
// bus hold and idle line properties, bound into the top level
// fail_count is read by the testbench at the end of the run
// ================================================
`timescale 1ns/10ps

module uart_assertions
(
   input logic        msoc_clk,
   input logic        rstn,
   input logic        bvalid_o,
   input logic        bready_i,
   input logic [1:0]  bresp_o,
   input logic        rvalid_o,
   input logic        rready_i,
   input logic [31:0] rdata_o,
   input logic [1:0]  rresp_o,
   input logic        uart_tx_o
);

   int fail_count = 0;

   b_hold: assert property (@(posedge msoc_clk) disable iff (!rstn)
      bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
   else
   begin
      fail_count++;
      $error("bvalid dropped or bresp changed before bready");
   end

   r_hold: assert property (@(posedge msoc_clk) disable iff (!rstn)
      rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
   else
   begin
      fail_count++;
      $error("rvalid dropped or read response changed before rready");
   end

   tx_idle: assert property (@(posedge msoc_clk) !rstn |-> uart_tx_o)
   else
   begin
      fail_count++;
      $error("uart_tx_o not high during reset");
   end

endmodule

bind periph_uart_top uart_assertions u_assert (
   .msoc_clk(msoc_clk), .rstn(rstn),
   .bvalid_o(bvalid_o), .bready_i(bready_i), .bresp_o(bresp_o),
   .rvalid_o(rvalid_o), .rready_i(rready_i), .rdata_o(rdata_o), .rresp_o(rresp_o),
   .uart_tx_o(uart_tx_o)
);

// File: dv/tb_clkgen.sv
// ================================================
// 4 ns clock, reset low for RESET_CYCLES rising edges
// ================================================
`timescale 1ns/10ps

module tb_clkgen
#(
   parameter int RESET_CYCLES = 8
)
(
   output logic msoc_clk_o,
   output logic rstn_o
);

   initial
   begin
      msoc_clk_o = 1'b0;
      forever #2 msoc_clk_o = ~msoc_clk_o;
   end

   initial
   begin
      rstn_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge msoc_clk_o);
      #1 rstn_o = 1'b1;   // released off the edge
   end

endmodule

// File: dv/tb_top.sv
// ================================================
// AXI4-Lite UART testbench, baud 16, inputs driven 1 ns after the edge
// loop_sel routes uart_tx_o back to uart_rx_i
// ================================================
`timescale 1ns/10ps
`include "periph_consts.svh"

module tb_top;

   localparam int BAUD       = 16;
   localparam int NUM_LOOP   = 8;
   localparam int MAX_CYCLES = 20000;   // tests need about 3000 at baud 16

   logic                    msoc_clk, rstn;
   logic [`AXI_ADDR_W-1:0]  awaddr, araddr;
   logic [`AXI_DATA_W-1:0]  wdata, rdata;
   logic [3:0]              wstrb;
   logic                    awvalid, awready, wvalid, wready, bvalid, bready;
   logic                    arvalid, arready, rvalid, rready;
   logic [1:0]              bresp, rresp;
   logic                    uart_rx, uart_tx, uart_irq;
   logic [`LED_W-1:0]       led;
   logic [`DIP_W-1:0]       dip;
   logic                    loop_sel, tb_line;
   integer                  seed;
   int                      err_count = 0;
   int                      check_count = 0;
   int                      test_err_base = 0;
   int                      cycles = 0;
   logic [31:0]             exp_q[$];
   logic [31:0]             got_q[$];

   assign uart_rx = loop_sel ? uart_tx : tb_line;

   tb_clkgen #(.RESET_CYCLES(8)) u_clkgen (.msoc_clk_o(msoc_clk), .rstn_o(rstn));

   periph_uart_top UUT (
      .msoc_clk(msoc_clk), .rstn(rstn),
      .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
      .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
      .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
      .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
      .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready),
      .uart_rx_i(uart_rx), .uart_tx_o(uart_tx), .uart_irq_o(uart_irq),
      .led_o(led), .dip_i(dip)
   );

   // expected REG_RXDATA word while the entry sits at the head
   function automatic logic [31:0] ref_rx_word(input logic [7:0] b, input logic err);
      return {22'd0, 1'b0, err, b};
   endfunction

   function automatic logic [31:0] status_word(input logic [4:0] tx_cnt,
                                               input logic [4:0] rx_cnt);
      return {18'd0, rx_cnt, tx_cnt, rx_cnt == 5'd16, rx_cnt == 5'd0,
              tx_cnt == 5'd16, tx_cnt == 5'd0};
   endfunction

   function automatic logic [7:0] reg_addr(input periph_pkg::reg_addr_e idx);
      return {idx, 2'b00};
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic end_test(input string name);
      $display("test %s finished with %0d errors", name, err_count - test_err_base);
      test_err_base = err_count;
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      logic aw_done, w_done;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(posedge msoc_clk);
      #1;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      while (!(aw_done && w_done))
      begin
         @(negedge msoc_clk);
         if (awvalid && awready)
            aw_done = 1'b1;   // taken at the next edge
         if (wvalid && wready)
            w_done = 1'b1;
         @(posedge msoc_clk);
         #1;
         if (aw_done)
            awvalid = 1'b0;
         if (w_done)
            wvalid = 1'b0;
      end
      @(negedge msoc_clk);
      while (!bvalid)
         @(negedge msoc_clk);
      repeat (2) @(posedge msoc_clk);   // B channel stalled two cycles
      #1;
      bready = 1'b1;
      @(negedge msoc_clk);
      resp = bresp;
      @(posedge msoc_clk);
      #1;
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      logic done;
      done = 1'b0;
      @(posedge msoc_clk);
      #1;
      araddr  = addr;
      arvalid = 1'b1;
      while (!done)
      begin
         @(negedge msoc_clk);
         done = arready;
         @(posedge msoc_clk);
         #1;
      end
      arvalid = 1'b0;
      @(negedge msoc_clk);
      while (!rvalid)
         @(negedge msoc_clk);
      repeat (2) @(posedge msoc_clk);   // R channel stalled two cycles
      #1;
      rready = 1'b1;
      @(negedge msoc_clk);
      data = rdata;
      resp = rresp;
      @(posedge msoc_clk);
      #1;
      rready = 1'b0;
   endtask

   // 8N1 frame on tb_line, stop bit level given, then two idle bit times
   task automatic drive_frame(input logic [7:0] b, input logic stop);
      logic [9:0] bits;
      bits = {stop, b, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(posedge msoc_clk);
         #1 tb_line = bits[i];
         repeat (BAUD - 1) @(posedge msoc_clk);
      end
      @(posedge msoc_clk);
      #1 tb_line = 1'b1;
      repeat (2 * BAUD) @(posedge msoc_clk);
   endtask

   task automatic wait_rx_data();
      while (!uart_irq)
         @(negedge msoc_clk);
   endtask

   task automatic drain_compare();
      while (got_q.size() != 0)
         @(negedge msoc_clk);
   endtask

   always @(negedge msoc_clk)
      while (exp_q.size() > 0 && got_q.size() > 0)
         check_value(got_q.pop_front(), exp_q.pop_front(), "rx entry");

   always @(posedge msoc_clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: tests still running after %0d clock cycles", MAX_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] rd;
      logic [1:0]  resp;
      logic [7:0]  b;
      logic [7:0]  led_val;
      int          total;
      seed     = 32'h9c1a;
      awaddr   = '0;
      awvalid  = 1'b0;
      wdata    = '0;
      wstrb    = 4'hF;
      wvalid   = 1'b0;
      bready   = 1'b0;
      araddr   = '0;
      arvalid  = 1'b0;
      rready   = 1'b0;
      dip      = 16'h5A3C;
      loop_sel = 1'b0;
      tb_line  = 1'b1;
      wait (rstn);
      repeat (2) @(posedge msoc_clk);

      axi_read(reg_addr(periph_pkg::REG_BAUD), rd, resp);
      check_value(rd, 32'(`UART_BAUD_DEFAULT), "baud after reset");
      axi_read(reg_addr(periph_pkg::REG_STATUS), rd, resp);
      check_value(rd, status_word(5'd0, 5'd0), "status after reset");
      @(negedge msoc_clk);
      check_value(32'(led), 32'd0, "led_o after reset");
      check_value(32'(uart_irq), 32'd0, "irq after reset");
      check_value(32'(uart_tx), 32'd1, "tx line after reset");
      end_test("reset state");

      axi_write(reg_addr(periph_pkg::REG_BAUD), 32'(BAUD), resp);
      check_value(32'(resp), 32'(periph_pkg::AXI_OKAY), "baud write response");
      axi_read(reg_addr(periph_pkg::REG_BAUD), rd, resp);
      check_value(rd, 32'(BAUD), "baud read back");
      check_value(32'(resp), 32'(periph_pkg::AXI_OKAY), "baud read response");
      led_val = 8'($random(seed));
      axi_write(reg_addr(periph_pkg::REG_LED), {24'd0, led_val}, resp);
      check_value(32'(resp), 32'(periph_pkg::AXI_OKAY), "led write response");
      axi_read(reg_addr(periph_pkg::REG_LED), rd, resp);
      check_value(rd, {24'd0, led_val}, "led read back");
      @(negedge msoc_clk);
      check_value(32'(led), 32'(led_val), "led_o value");
      axi_read(reg_addr(periph_pkg::REG_DIP), rd, resp);
      check_value(rd, {16'd0, dip}, "dip read");
      axi_write(8'h1C, 32'h1234_5678, resp);   // first index past REG_DIP
      check_value(32'(resp), 32'(periph_pkg::AXI_SLVERR), "unmapped write response");
      axi_read(8'h1C, rd, resp);
      check_value(32'(resp), 32'(periph_pkg::AXI_SLVERR), "unmapped read response");
      check_value(rd, `REG_BAD_DATA, "unmapped read data");
      end_test("register access");

      loop_sel = 1'b1;
      for (int i = 0; i < NUM_LOOP; i++)
      begin
         b = 8'($random(seed));
         exp_q.push_back(ref_rx_word(b, 1'b0));
         axi_write(reg_addr(periph_pkg::REG_TXDATA), {24'd0, b}, resp);
      end
      for (int i = 0; i < NUM_LOOP; i++)
      begin
         wait_rx_data();
         axi_read(reg_addr(periph_pkg::REG_RXDATA), rd, resp);
         got_q.push_back(rd);
         axi_write(reg_addr(periph_pkg::REG_RXPOP), 32'd0, resp);
      end
      drain_compare();
      axi_read(reg_addr(periph_pkg::REG_RXDATA), rd, resp);
      check_value(32'(rd[9]), 32'd1, "rx empty flag after draining");
      @(negedge msoc_clk);
      check_value(32'(uart_irq), 32'd0, "irq after draining");
      repeat (BAUD) @(posedge msoc_clk);   // rest of the last stop bit
      #1 loop_sel = 1'b0;
      end_test("loopback");

      b = 8'($random(seed));
      exp_q.push_back(ref_rx_word(b, 1'b1));
      drive_frame(b, 1'b0);
      wait_rx_data();
      axi_read(reg_addr(periph_pkg::REG_RXDATA), rd, resp);
      got_q.push_back(rd);
      axi_write(reg_addr(periph_pkg::REG_RXPOP), 32'd0, resp);
      drain_compare();
      end_test("framing error");

      for (int i = 0; i < 3; i++)
         drive_frame(8'($random(seed)), 1'b1);
      axi_read(reg_addr(periph_pkg::REG_STATUS), rd, resp);
      check_value(32'(rd[13:9]), 32'd3, "rx count after three frames");
      check_value(32'(rd[2]), 32'd0, "rx empty flag after three frames");
      end_test("fifo fill count");

      total = err_count + UUT.u_assert.fail_count;
      $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
               check_count, err_count, UUT.u_assert.fail_count);
      if (total == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: flist.f
+incdir+include
source/periph_pkg.sv
source/sync_fifo.sv
source/axil_slave.sv
source/uart_regs.sv
source/uart_tx.sv
source/uart_rx.sv
source/periph_uart_top.sv
dv/uart_assertions.sv
dv/tb_clkgen.sv
dv/tb_top.sv

// File: Makefile
# Verilator build and run of the UART peripheral testbench

all: run

obj_dir/Vtb_top: flist.f $(wildcard source/*.sv dv/*.sv include/*.svh)
	verilator --binary --timing --assert --top-module tb_top -f flist.f

run: obj_dir/Vtb_top
	@out=$$(./obj_dir/Vtb_top +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: all run clean
